// ==== Makefile ====
TOP = tb_spi_master

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f spi_master.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== common/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  import spi_timing_pkg::*;

  // --------------------------------------------------
  // Command word layouts, MSB first on the wire
  // --------------------------------------------------

  // Write layout with flag, register address and data byte
  typedef struct packed {
    logic                   is_write;           // 1 for write
    logic [HDR_WIDTH-2:0]   addr;
    logic [READ_WIDTH-1:0]  wdata;
  } spi_wr_cmd_t;

  // Read layout where only the header goes out
  typedef struct packed {
    logic                   is_write;           // 0 for read
    logic [HDR_WIDTH-2:0]   addr;
    logic [READ_WIDTH-1:0]  pad;
  } spi_rd_cmd_t;

  // Same 12 bits read two ways
  typedef union packed {
    spi_wr_cmd_t wr;
    spi_rd_cmd_t rd;
  } spi_cmd_u;

endpackage

// ==== common/spi_timing_pkg.sv ====
package spi_timing_pkg;

  // --------------------------------------------------
  // Word widths
  // --------------------------------------------------
  localparam int CMD_WIDTH  = 12;               // Full command word
  localparam int READ_WIDTH = 8;                // Byte returned by the slave
  localparam int HDR_WIDTH  = 4;                // Flag plus address ahead of a read

  // --------------------------------------------------
  // Clocking and counters
  // --------------------------------------------------
  localparam int CLK_DIV_DEFAULT = 4;           // sclk half-period in clk cycles
  localparam int BIT_CNT_W       = 4;           // Holds up to CMD_WIDTH

endpackage

// ==== rtl/spi_master.sv ====
`timescale 1ns/1ps

module spi_master #(
  parameter int CLK_DIV = spi_timing_pkg::CLK_DIV_DEFAULT
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [spi_timing_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                  cmd_vld,
  output logic                                  cmd_rdy,
  output logic                                  sclk,
  output logic                                  cs,
  output logic                                  mosi,
  input  logic                                  miso,
  output logic                                  read_vld,
  output logic [spi_timing_pkg::READ_WIDTH-1:0] read_data
);

  import spi_timing_pkg::*;

  logic                 load;
  logic                 run;
  logic                 start;
  logic                 rx_en;
  logic                 rise_tick;
  logic                 fall_tick;
  logic                 phase_done;
  logic [BIT_CNT_W-1:0] phase_bits;

  // --------------------------------------------------
  // Control
  // --------------------------------------------------
  spi_ctrl_fsm u_ctrl_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .phase_done (phase_done),
    .cmd_rdy    (cmd_rdy),
    .cs         (cs),
    .load       (load),
    .run        (run),
    .start      (start),
    .rx_en      (rx_en),
    .read_vld   (read_vld),
    .phase_bits (phase_bits)
  );

  spi_bit_timer #(
    .CLK_DIV (CLK_DIV)
  ) u_bit_timer (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .phase_bits (phase_bits),
    .start      (start),
    .sclk       (sclk),
    .rise_tick  (rise_tick),
    .fall_tick  (fall_tick),
    .phase_done (phase_done)
  );

  // --------------------------------------------------
  // Data path
  // --------------------------------------------------
  spi_tx_shifter u_tx_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .cmd_in    (cmd_in),
    .fall_tick (fall_tick),
    .mosi      (mosi)
  );

  spi_rx_shifter u_rx_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_en     (rx_en),
    .rise_tick (rise_tick),
    .miso      (miso),
    .read_data (read_data)
  );

endmodule

// ==== spi_engine/spi_bit_timer.sv ====
`timescale 1ns/1ps

module spi_bit_timer #(
  parameter int CLK_DIV = spi_timing_pkg::CLK_DIV_DEFAULT
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 run,
  input  logic [spi_timing_pkg::BIT_CNT_W-1:0] phase_bits,
  input  logic                                 start,
  output logic                                 sclk,
  output logic                                 rise_tick,
  output logic                                 fall_tick,
  output logic                                 phase_done
);

  import spi_timing_pkg::*;

  localparam int DIV_W = $clog2(CLK_DIV);

  logic [DIV_W-1:0]     div_cnt;
  logic [BIT_CNT_W-1:0] bits_left;
  logic                 half_done;

  assign half_done  = run && (div_cnt == DIV_W'(CLK_DIV - 1));
  assign rise_tick  = half_done && !sclk;
  assign fall_tick  = half_done && sclk;
  assign phase_done = fall_tick && (bits_left == BIT_CNT_W'(1));  // Fall that empties it

  // --------------------------------------------------
  // Half-period divider
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      sclk    <= 1'b0;
    end
    else if (!run)
    begin
      div_cnt <= '0;
      sclk    <= 1'b0;                          // Mode 0 idle level
    end
    else if (half_done)
    begin
      div_cnt <= '0;
      sclk    <= ~sclk;
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // Bits remaining in the current phase
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bits_left <= '0;
    else if (start)
      bits_left <= phase_bits;                  // Wins over the header's last fall
    else if (fall_tick && bits_left != '0)
      bits_left <= bits_left - 1'b1;
  end

  a_sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    !run |-> !sclk);

endmodule

// ==== spi_engine/spi_ctrl_fsm.sv ====
`timescale 1ns/1ps

module spi_ctrl_fsm (
  input  logic                             clk,
  input  logic                             rst_n,
  input  spi_cmd_pkg::spi_cmd_u            cmd_in,
  input  logic                             cmd_vld,
  input  logic                             phase_done,
  output logic                             cmd_rdy,
  output logic                             cs,
  output logic                             load,
  output logic                             run,
  output logic                             start,
  output logic                             rx_en,
  output logic                             read_vld,
  output logic [spi_timing_pkg::BIT_CNT_W-1:0] phase_bits
);

  import spi_timing_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    SELECT,
    SEND,
    RECV,
    FINISH
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   op_write;
  logic   accept;

  assign accept = cmd_vld && cmd_rdy;
  assign load   = accept;                       // Shifter grabs the word on accept

  // Counter reload at SELECT and at the end of a read header
  assign start = (state == SELECT) || (state == SEND && phase_done && !op_write);

  always_comb
  begin
    if (state == SELECT)
      phase_bits = op_write ? BIT_CNT_W'(CMD_WIDTH) : BIT_CNT_W'(HDR_WIDTH);
    else
      phase_bits = BIT_CNT_W'(READ_WIDTH);      // Only the receive phase reloads later
  end

  // --------------------------------------------------
  // State register and next state
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:   if (accept) state_nxt = SELECT;
      SELECT: state_nxt = SEND;
      SEND:   if (phase_done) state_nxt = op_write ? FINISH : RECV;
      RECV:   if (phase_done) state_nxt = FINISH;
      FINISH: state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  // --------------------------------------------------
  // Registered outputs
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_rdy  <= 1'b1;
      cs       <= 1'b1;
      run      <= 1'b0;
      rx_en    <= 1'b0;
      read_vld <= 1'b0;
      op_write <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            cmd_rdy  <= 1'b0;
            op_write <= cmd_in.rd.is_write;     // Read view picks the sequence
          end
          else
            cmd_rdy <= 1'b1;                    // One cycle after cs rises
        end
        SELECT:
        begin
          cs  <= 1'b0;
          run <= 1'b1;
        end
        SEND:
        begin
          if (phase_done)
          begin
            if (op_write)
              run <= 1'b0;
            else
              rx_en <= 1'b1;                    // sclk keeps running into RECV
          end
        end
        RECV:
        begin
          if (phase_done)
          begin
            run   <= 1'b0;
            rx_en <= 1'b0;
          end
        end
        FINISH:
        begin
          cs       <= 1'b1;
          read_vld <= !op_write;
        end
        default: ;
      endcase
    end
  end

  a_rdy_cs_high: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> cs);

  // A write must finish without any result pulse
  a_no_vld_on_write: assert property (@(posedge clk) disable iff (!rst_n)
    (load && cmd_in.rd.is_write) |=> (!read_vld throughout cmd_rdy[->1]));

endmodule

// ==== spi_engine/spi_rx_shifter.sv ====
`timescale 1ns/1ps

module spi_rx_shifter (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  rx_en,
  input  logic                                  rise_tick,
  input  logic                                  miso,
  output logic [spi_timing_pkg::READ_WIDTH-1:0] read_data
);

  import spi_timing_pkg::*;

  logic [BIT_CNT_W-1:0] sample_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_data <= '0;
    else if (rise_tick && rx_en)
      read_data <= {read_data[READ_WIDTH-2:0], miso};  // MSB arrives first
  end

  // Samples taken in the current receive phase
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sample_cnt <= '0;
    else if (!rx_en)
      sample_cnt <= '0;
    else if (rise_tick)
      sample_cnt <= sample_cnt + 1'b1;
  end

  a_max_samples: assert property (@(posedge clk) disable iff (!rst_n)
    (rise_tick && rx_en) |-> (sample_cnt < BIT_CNT_W'(READ_WIDTH)));

endmodule

// ==== spi_engine/spi_tx_shifter.sv ====
`timescale 1ns/1ps

module spi_tx_shifter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  spi_cmd_pkg::spi_cmd_u cmd_in,
  input  logic                  fall_tick,
  output logic                  mosi
);

  import spi_timing_pkg::*;

  logic [CMD_WIDTH-1:0] shift_q;

  // Read commands send their header and then only zeros
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      shift_q <= '0;
    else if (load)
      shift_q <= {cmd_in.wr.is_write,
                  cmd_in.wr.addr,
                  cmd_in.wr.is_write ? cmd_in.wr.wdata : READ_WIDTH'(0)};
    else if (fall_tick)
      shift_q <= {shift_q[CMD_WIDTH-2:0], 1'b0};  // Next bit on sclk fall
  end

  assign mosi = shift_q[CMD_WIDTH-1];           // MSB first

endmodule

// ==== spi_master.f ====
common/spi_timing_pkg.sv
common/spi_cmd_pkg.sv
spi_engine/spi_ctrl_fsm.sv
spi_engine/spi_bit_timer.sv
spi_engine/spi_tx_shifter.sv
spi_engine/spi_rx_shifter.sv
rtl/spi_master.sv
verif/spi_checker.sv
verif/tb_spi_master.sv

// ==== verif/spi_checker.sv ====
`timescale 1ns/1ps

module spi_checker #(
  parameter int CLK_DIV = spi_timing_pkg::CLK_DIV_DEFAULT
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  sclk,
  input  logic                                  cs,
  input  logic                                  mosi,
  input  logic                                  cmd_rdy,
  input  logic                                  read_vld,
  input  logic [spi_timing_pkg::READ_WIDTH-1:0] read_data,
  input  logic                                  exp_push,
  input  logic [spi_timing_pkg::CMD_WIDTH-1:0]  exp_word,
  input  logic [spi_timing_pkg::READ_WIDTH-1:0] exp_byte,
  output int                                    error_count,
  output int                                    done_count
);

  import spi_timing_pkg::*;

  localparam int XFER_CYCLES = 24 * CLK_DIV + 1;  // cs low time in clk cycles
  localparam int LOW_LIMIT   = 4 * XFER_CYCLES;

  logic [CMD_WIDTH-1:0]  word_q [$];
  logic [READ_WIDTH-1:0] byte_q [$];
  logic [CMD_WIDTH-1:0]  cur_word;
  logic [READ_WIDTH-1:0] cur_byte;
  logic [CMD_WIDTH-1:0]  mosi_bits;
  logic                  sclk_q;
  logic                  cs_q;
  logic                  in_xfer;
  logic                  reset_checked;
  logic                  vld_exp;
  logic                  rdy_due;
  int                    rise_cnt;
  int                    low_cnt;
  int                    err_cnt  = 0;
  int                    done_cnt = 0;

  assign error_count = err_cnt;
  assign done_count  = done_cnt;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      err_cnt++;
    end
  endtask

  // Bits seen on mosi for one command
  function automatic logic [CMD_WIDTH-1:0] expected_mosi(input logic [CMD_WIDTH-1:0] word);
    if (word[CMD_WIDTH-1])
      return word;                                        // Write sends the whole word
    else
      return {word[CMD_WIDTH-1 -: HDR_WIDTH], {READ_WIDTH{1'b0}}};
  endfunction

  // --------------------------------------------------
  // Sampled on the falling clk edge
  // --------------------------------------------------
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      sclk_q        = 1'b0;
      cs_q          = 1'b1;
      in_xfer       = 1'b0;
      reset_checked = 1'b0;
      rdy_due       = 1'b0;
    end
    else
    begin
      if (!reset_checked)
      begin
        compare_value("cs", 32'(1'b1), 32'(cs));
        compare_value("sclk", 32'(1'b0), 32'(sclk));
        compare_value("cmd_rdy", 32'(1'b1), 32'(cmd_rdy));
        compare_value("read_vld", 32'(1'b0), 32'(read_vld));
        compare_value("mosi", 32'(1'b0), 32'(mosi));
        compare_value("read_data", 32'(0), 32'(read_data));
        reset_checked = 1'b1;
      end

      if (exp_push)
      begin
        word_q.push_back(exp_word);
        byte_q.push_back(exp_byte);
      end

      if (rdy_due)
      begin
        compare_value("cmd_rdy", 32'(1'b1), 32'(cmd_rdy));  // Back one cycle after cs rises
        rdy_due = 1'b0;
      end

      vld_exp = 1'b0;
      if (cs_q && !cs)                                    // cs fell
      begin
        if (word_q.size() == 0)
        begin
          $display("Unexpected transfer: cs fell with no accepted command pending");
          err_cnt++;
          cur_word = '0;
          cur_byte = '0;
        end
        else
        begin
          cur_word = word_q.pop_front();
          cur_byte = byte_q.pop_front();
        end
        in_xfer   = 1'b1;
        rise_cnt  = 0;
        low_cnt   = 0;
        mosi_bits = '0;
      end

      if (!cs)
      begin
        low_cnt++;
        compare_value("cmd_rdy", 32'(1'b0), 32'(cmd_rdy));
        if (low_cnt == LOW_LIMIT)
        begin
          $display("Timeout: cs held low for %0d cycles", LOW_LIMIT);
          err_cnt++;
        end
        if (sclk && !sclk_q)
        begin
          rise_cnt++;
          mosi_bits = {mosi_bits[CMD_WIDTH-2:0], mosi};
        end
      end
      else if (sclk)
      begin
        $display("Protocol error: sclk is high while cs is high");
        err_cnt++;
      end

      if (!cs_q && cs && in_xfer)                         // cs rose
      begin
        compare_value("sclk rises", 32'(CMD_WIDTH), 32'(rise_cnt));
        compare_value("mosi", 32'(expected_mosi(cur_word)), 32'(mosi_bits));
        compare_value("cs low cycles", 32'(XFER_CYCLES), 32'(low_cnt));
        if (!cur_word[CMD_WIDTH-1])
        begin
          vld_exp = 1'b1;
          compare_value("read_data", 32'(cur_byte), 32'(read_data));
        end
        in_xfer = 1'b0;
        rdy_due = 1'b1;
        done_cnt++;
      end

      compare_value("read_vld", 32'(vld_exp), 32'(read_vld));  // One pulse per read only
      sclk_q = sclk;
      cs_q   = cs;
    end
  end

endmodule

// ==== verif/spi_stim.txt ====
// Columns: command word, slave response byte, idle gap in cycles, line kind (all hex)
// Kind 0 sends a command, 1 strobes cmd_vld during a transfer, f ends the list
a5c 00 04 0
3a5 96 02 0
f81 00 00 0
1ff 00 00 1
4c0 3c 00 0
e00 00 20 1
c0f 00 00 0
7ff c3 06 0
800 00 00 0
000 01 00 0
2aa 80 00 0
0f0 00 10 1
9e7 00 03 0
6ff ff 00 0
b18 00 00 0
000 00 00 f

// ==== verif/tb_spi_master.sv ====
`timescale 1ns/1ps

module tb_spi_master;

  import spi_timing_pkg::*;

  localparam int CLK_DIV      = CLK_DIV_DEFAULT;
  localparam int MAX_LINES    = 64;
  localparam int RDY_TIMEOUT  = 32 * CLK_DIV + 32;
  localparam int DONE_TIMEOUT = 4 * (24 * CLK_DIV + 4);

  localparam logic [CMD_WIDTH-1:0] KIND_BUSY = CMD_WIDTH'(1);   // Strobe mid-transfer
  localparam logic [CMD_WIDTH-1:0] KIND_END  = CMD_WIDTH'(15);

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  miso;
  logic                  read_vld;
  logic [READ_WIDTH-1:0] read_data;

  logic                  exp_push;
  logic [CMD_WIDTH-1:0]  exp_word;
  logic [READ_WIDTH-1:0] exp_byte;
  logic [READ_WIDTH-1:0] slave_byte;                    // Response of the transfer in flight
  logic                  timed_out;
  int                    check_errors;
  int                    checks_done;
  int                    stim_errors;
  int                    sent_count;

  logic [CMD_WIDTH-1:0]  stim_mem [0:4*MAX_LINES-1];

  spi_master #(
    .CLK_DIV (CLK_DIV)
  ) spi_master_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_checker #(
    .CLK_DIV (CLK_DIV)
  ) checker_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .cmd_rdy     (cmd_rdy),
    .read_vld    (read_vld),
    .read_data   (read_data),
    .exp_push    (exp_push),
    .exp_word    (exp_word),
    .exp_byte    (exp_byte),
    .error_count (check_errors),
    .done_count  (checks_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;                              // 8 ns period
  end

  // --------------------------------------------------
  // Command driving
  // --------------------------------------------------
  task automatic wait_for_ready();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!cmd_rdy && cycles < RDY_TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!cmd_rdy)
    begin
      $display("Timeout: cmd_rdy stayed low for %0d cycles", RDY_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic send_command(input logic [CMD_WIDTH-1:0] word,
                              input logic [READ_WIDTH-1:0] resp);
    cmd_in     <= word;
    cmd_vld    <= 1'b1;
    exp_word   <= word;
    exp_byte   <= resp;
    exp_push   <= 1'b1;
    slave_byte <= resp;
    @(posedge clk);
    cmd_vld    <= 1'b0;
    exp_push   <= 1'b0;
    sent_count++;
  endtask

  task automatic strobe_while_busy(input logic [CMD_WIDTH-1:0] word);
    @(posedge clk);
    if (cmd_rdy)
    begin
      $display("Stimulus error: cmd_rdy was high where a busy strobe was planned");
      stim_errors++;
    end
    else
    begin
      cmd_in  <= word;
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
  endtask

  task automatic wait_for_checker();
    int cycles;
    cycles = 0;
    while (checks_done < sent_count && cycles < DONE_TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (checks_done < sent_count)
    begin
      $display("Timeout: only %0d of %0d transfers completed", checks_done, sent_count);
      timed_out = 1'b1;
    end
    repeat (2 * CLK_DIV) @(posedge clk);                // Catch a late read_vld
  endtask

  initial
  begin : stimulus
    int line_idx;
    int gap;
    rst_n       = 1'b0;
    cmd_in      = '0;
    cmd_vld     = 1'b0;
    exp_push    = 1'b0;
    exp_word    = '0;
    exp_byte    = '0;
    slave_byte  = '0;
    timed_out   = 1'b0;
    stim_errors = 0;
    sent_count  = 0;
    $readmemh("verif/spi_stim.txt", stim_mem);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    line_idx = 0;
    while (line_idx < MAX_LINES && !timed_out)
    begin
      if (stim_mem[4*line_idx+3] == KIND_END)
        break;
      if (stim_mem[4*line_idx+3] == KIND_BUSY)
        strobe_while_busy(stim_mem[4*line_idx]);
      else
      begin
        wait_for_ready();
        if (!timed_out)
          send_command(stim_mem[4*line_idx], stim_mem[4*line_idx+1][READ_WIDTH-1:0]);
      end
      gap = int'(stim_mem[4*line_idx+2]);
      repeat (gap) @(posedge clk);
      line_idx++;
    end

    if (!timed_out)
      wait_for_checker();

    $display("Errors: %0d checker, %0d stimulus, %0d timeout over %0d commands",
             check_errors, stim_errors, timed_out, sent_count);
    if (check_errors == 0 && stim_errors == 0 && !timed_out)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Slave model on miso
  // --------------------------------------------------
  initial
  begin : slave_model
    logic sclk_prev;
    int   fall_cnt;
    int   bit_idx;
    miso      = 1'b0;
    sclk_prev = 1'b0;
    fall_cnt  = 0;
    forever
    begin
      @(posedge clk);
      if (cs)
        fall_cnt = 0;
      else if (sclk_prev && !sclk)
      begin
        fall_cnt = fall_cnt + 1;
        bit_idx  = READ_WIDTH - 1 - (fall_cnt - HDR_WIDTH);
        if (fall_cnt >= HDR_WIDTH && bit_idx >= 0)
          miso <= slave_byte[bit_idx];                  // MSB right after the header
      end
      sclk_prev = sclk;
    end
  end

endmodule
